// ==== source/decode_pkg.sv ====
package decode_pkg;

  ////////////////////
  // sizes and build switches
  ////////////////////

  localparam int   INSTR_W  = 32;
  localparam logic RV32M_EN = 1'b1; // mul/div extension present

  ////////////////////
  // field positions
  ////////////////////

  localparam int FLD_CLASS_HI  = 4;  // major class
  localparam int FLD_CLASS_LO  = 0;
  localparam int FLD_SUB_HI    = 7;  // sub opcode
  localparam int FLD_SUB_LO    = 5;
  localparam int FLD_FUNCT3_HI = 14;
  localparam int FLD_FUNCT3_LO = 12;
  localparam int BIT_ALT       = 28; // sub, sra, link write
  localparam int BIT_MEXT      = 25; // rv32m in reg alu group
  localparam int FLD_SYSFN_HI  = 23; // system function / csr address
  localparam int FLD_SYSFN_LO  = 12;
  localparam int FLD_CSRFN_HI  = 30;
  localparam int FLD_CSRFN_LO  = 29;
  localparam int BIT_CSRIMM    = 31; // rs1 used as immediate

  // major classes
  localparam logic [4:0] OP_LOAD    = 5'h00;
  localparam logic [4:0] OP_ALU_IMM = 5'h04;
  localparam logic [4:0] OP_STORE   = 5'h08;
  localparam logic [4:0] OP_ALU_REG = 5'h0c;
  localparam logic [4:0] OP_U_IMM   = 5'h0d;
  localparam logic [4:0] OP_BRANCH  = 5'h18;
  localparam logic [4:0] OP_SYSTEM  = 5'h1c;

  // sub opcodes
  localparam logic [2:0] OPCODE_ALU   = 3'b000; // in OP_ALU_REG
  localparam logic [2:0] OPCODE_SHIFT = 3'b001; // in OP_ALU_REG
  localparam logic [2:0] OPCODE_JALR  = 3'b111; // in OP_BRANCH
  localparam logic [2:0] OPCODE_JAL   = 3'b011; // in OP_U_IMM
  localparam logic [2:0] OPCODE_AUIPC = 3'b101;
  localparam logic [2:0] OPCODE_LUI   = 3'b110;

  // system functions
  localparam logic [11:0] SYS_ECALL   = 12'h000;
  localparam logic [11:0] SYS_EBREAK  = 12'h001;
  localparam logic [11:0] SYS_MRET    = 12'h302;
  localparam logic [11:0] SYS_WFI     = 12'h105;
  localparam logic [11:0] CSR_MSTATUS = 12'h300;

  ////////////////////
  // encodings
  ////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLTS, ALU_SLTU,
    ALU_XOR, ALU_OR, ALU_AND, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_EQ, ALU_NE,
    ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REGA, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;
  typedef enum logic {OP_B_REGB, OP_B_IMM} op_b_sel_e;
  typedef enum logic {IMMA_ZERO, IMMA_Z} imm_a_sel_e;

  typedef enum logic [2:0] {
    IMMB_I, IMMB_S, IMMB_SB, IMMB_U, IMMB_UJ, IMMB_PCINCR
  } imm_b_sel_e;

  typedef enum logic [1:0] {MD_OP_MULL, MD_OP_MULH, MD_OP_DIV, MD_OP_REM} md_op_e;
  typedef enum logic [1:0] {CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;
  typedef enum logic [1:0] {DT_WORD, DT_HALF, DT_BYTE} data_type_e;

  ////////////////////
  // control word
  ////////////////////

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_a_sel_e imm_a_sel;
    imm_b_sel_e imm_b_sel;
    logic       regfile_we;
  } oper_sel_t;

  typedef struct packed {
    logic       mult_en;
    logic       div_en;
    md_op_e     md_op;
    logic [1:0] md_signed; // {rs2 signed, rs1 signed}
    logic       jump;
    logic       branch;
    logic       regfile_we_ra;
  } mdj_ctrl_t;

  typedef struct packed {
    logic       req;
    logic       we;
    data_type_e data_type;
    logic       sign_ext;
    logic [1:0] reg_offset;
  } lsu_ctrl_t;

  typedef struct packed {
    logic    csr_access;
    csr_op_e csr_op;
    logic    csr_status; // mstatus touched
    logic    ecall;
    logic    ebreak;
    logic    mret;
    logic    wfi_flush;
  } sys_ctrl_t;

  typedef struct packed {
    oper_sel_t oper;
    mdj_ctrl_t mdj;
    lsu_ctrl_t lsu;
    sys_ctrl_t sys;
    logic      illegal;
  } ctrl_word_t;

  // idle values when a decoder does not own the class
  localparam oper_sel_t OPER_DEFAULT = '{ALU_ADD, OP_A_REGA, OP_B_REGB, IMMA_ZERO, IMMB_I, 1'b0};
  localparam mdj_ctrl_t MDJ_DEFAULT  = '{1'b0, 1'b0, MD_OP_MULL, 2'b00, 1'b0, 1'b0, 1'b0};
  localparam lsu_ctrl_t LSU_DEFAULT  = '{1'b0, 1'b0, DT_WORD, 1'b0, 2'b00};
  localparam sys_ctrl_t SYS_DEFAULT  = '{1'b0, CSR_OP_NONE, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

endpackage

// ==== source/exec_decoder.sv ====
`timescale 1ns/1ps

module exec_decoder import decode_pkg::*; (
  input  logic [INSTR_W-1:0] instr_i,
  input  logic               branch_phase_i, // 1 compare, 0 target
  input  logic               jump_phase_i,   // 1 target, 0 link
  output logic               exec_hit_o,
  output logic               exec_illegal_o,
  output oper_sel_t          oper_o,
  output mdj_ctrl_t          mdj_o
);

  logic [4:0] cls;
  logic [2:0] sub;
  logic [2:0] funct3;
  logic       alt;

  logic       hit;
  logic       illegal;
  oper_sel_t  oper;
  mdj_ctrl_t  mdj;

  assign cls    = instr_i[FLD_CLASS_HI:FLD_CLASS_LO];
  assign sub    = instr_i[FLD_SUB_HI:FLD_SUB_LO];
  assign funct3 = instr_i[FLD_FUNCT3_HI:FLD_FUNCT3_LO];
  assign alt    = instr_i[BIT_ALT];

  always_comb begin
    hit     = 1'b0;
    illegal = 1'b0;
    oper    = OPER_DEFAULT;
    mdj     = MDJ_DEFAULT;

    unique case (cls)
      ////////////////////
      // register alu
      ////////////////////
      OP_ALU_REG: begin
        hit = 1'b1;
        oper.regfile_we = 1'b1;
        if (sub == OPCODE_ALU && instr_i[BIT_MEXT]) begin
          // rv32m operand signedness per funct3
          case (funct3)
            3'b000:  begin mdj.md_op = MD_OP_MULL; mdj.md_signed = 2'b00; end // mul
            3'b001:  begin mdj.md_op = MD_OP_MULH; mdj.md_signed = 2'b11; end // mulh
            3'b010:  begin mdj.md_op = MD_OP_MULH; mdj.md_signed = 2'b01; end // mulhsu
            3'b011:  begin mdj.md_op = MD_OP_MULH; mdj.md_signed = 2'b00; end // mulhu
            3'b100:  begin mdj.md_op = MD_OP_DIV;  mdj.md_signed = 2'b11; end // div
            3'b101:  begin mdj.md_op = MD_OP_DIV;  mdj.md_signed = 2'b00; end // divu
            3'b110:  begin mdj.md_op = MD_OP_REM;  mdj.md_signed = 2'b11; end // rem
            default: begin mdj.md_op = MD_OP_REM;  mdj.md_signed = 2'b00; end // remu
          endcase
          mdj.mult_en = ~funct3[2];
          mdj.div_en  = funct3[2];
          illegal     = alt | ~RV32M_EN; // no alt form for mul/div
        end else if (sub == OPCODE_ALU) begin
          case ({alt, funct3})
            4'b0_000: oper.alu_op = ALU_ADD;
            4'b1_000: oper.alu_op = ALU_SUB;
            4'b0_010: oper.alu_op = ALU_SLTS;
            4'b0_011: oper.alu_op = ALU_SLTU;
            4'b0_100: oper.alu_op = ALU_XOR;
            4'b0_110: oper.alu_op = ALU_OR;
            4'b0_111: oper.alu_op = ALU_AND;
            4'b0_001: oper.alu_op = ALU_SLL;
            4'b0_101: oper.alu_op = ALU_SRL;
            4'b1_101: oper.alu_op = ALU_SRA;
            default:  illegal = 1'b1;
          endcase
        end else if (sub == OPCODE_SHIFT) begin
          oper.op_b_sel = OP_B_IMM; // shamt in I imm
          case ({alt, funct3})
            4'b0_001: oper.alu_op = ALU_SLL;
            4'b0_101: oper.alu_op = ALU_SRL;
            4'b1_101: oper.alu_op = ALU_SRA;
            default:  illegal = 1'b1;
          endcase
        end else begin
          illegal = 1'b1;
        end
      end

      OP_ALU_IMM: begin
        hit = 1'b1;
        oper.regfile_we = 1'b1;
        oper.op_b_sel   = OP_B_IMM;
        case ({alt, sub}) // operator lives in the sub field here
          4'b0_000: oper.alu_op = ALU_ADD;
          4'b0_010: oper.alu_op = ALU_SLTS;
          4'b0_011: oper.alu_op = ALU_SLTU;
          4'b0_100: oper.alu_op = ALU_XOR;
          4'b0_110: oper.alu_op = ALU_OR;
          4'b0_111: oper.alu_op = ALU_AND;
          default:  illegal = 1'b1;
        endcase
      end

      ////////////////////
      // branch and jump
      ////////////////////
      OP_BRANCH: begin
        hit = 1'b1;
        if (sub == OPCODE_JALR) begin
          mdj.jump      = 1'b1;
          oper.op_b_sel = OP_B_IMM;
          if (jump_phase_i) begin
            oper.op_a_sel = OP_A_REGA;   // rs1 + I imm
          end else begin
            oper.op_a_sel   = OP_A_CURRPC; // link value
            oper.imm_b_sel  = IMMB_PCINCR;
            oper.regfile_we = alt;
          end
        end else begin
          mdj.branch = 1'b1;
          if (branch_phase_i) begin
            case ({alt, sub})
              4'b0_000: oper.alu_op = ALU_EQ;
              4'b0_001: oper.alu_op = ALU_NE;
              4'b0_010: oper.alu_op = ALU_LTS;
              4'b0_011: oper.alu_op = ALU_GES;
              4'b0_100: oper.alu_op = ALU_LTU;
              4'b0_101: oper.alu_op = ALU_GEU;
              default:  illegal = 1'b1;
            endcase
          end else begin
            oper.op_a_sel  = OP_A_CURRPC; // pc + SB imm
            oper.op_b_sel  = OP_B_IMM;
            oper.imm_b_sel = IMMB_SB;
          end
        end
      end

      OP_U_IMM: begin
        hit = 1'b1;
        oper.op_a_sel = OP_A_CURRPC;
        oper.op_b_sel = OP_B_IMM;
        oper.imm_b_sel = IMMB_U;
        case (sub)
          OPCODE_JAL: begin
            mdj.jump = 1'b1;
            if (jump_phase_i) begin
              oper.imm_b_sel = IMMB_UJ; // target
            end else begin
              oper.imm_b_sel    = IMMB_PCINCR;
              oper.regfile_we   = alt;
              mdj.regfile_we_ra = 1'b1;
            end
          end
          OPCODE_AUIPC: oper.regfile_we = 1'b1;
          OPCODE_LUI: begin
            oper.op_a_sel   = OP_A_IMM; // zero + U imm
            oper.regfile_we = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end

      default: ; // other classes belong to mem_sys_decoder
    endcase
  end

  assign exec_hit_o     = hit;
  assign exec_illegal_o = illegal;
  assign oper_o         = oper;
  assign mdj_o          = mdj;

  // branch and jump share the adder in different cycles
  always_comb begin
    a_jump_branch_excl: assert (!(mdj.jump && mdj.branch))
      else $error("jump and branch both set for instr %h", instr_i);
  end

endmodule

// ==== source/mem_sys_decoder.sv ====
`timescale 1ns/1ps

module mem_sys_decoder import decode_pkg::*; (
  input  logic [INSTR_W-1:0] instr_i,
  output logic               mem_hit_o,
  output logic               mem_illegal_o,
  output oper_sel_t          oper_o,
  output lsu_ctrl_t          lsu_o,
  output sys_ctrl_t          sys_o
);

  logic [4:0]  cls;
  logic [2:0]  sub;
  logic [11:0] sysfn;
  logic [1:0]  csrfn;
  logic        alt;

  logic        hit;
  logic        illegal;
  logic        csr_illegal;
  oper_sel_t   oper;
  lsu_ctrl_t   lsu;
  sys_ctrl_t   sys;

  assign cls   = instr_i[FLD_CLASS_HI:FLD_CLASS_LO];
  assign sub   = instr_i[FLD_SUB_HI:FLD_SUB_LO];
  assign sysfn = instr_i[FLD_SYSFN_HI:FLD_SYSFN_LO];
  assign csrfn = instr_i[FLD_CSRFN_HI:FLD_CSRFN_LO];
  assign alt   = instr_i[BIT_ALT];

  always_comb begin
    hit         = 1'b0;
    illegal     = 1'b0;
    csr_illegal = 1'b0;
    oper        = OPER_DEFAULT;
    lsu         = LSU_DEFAULT;
    sys         = SYS_DEFAULT;

    unique case (cls)
      ////////////////////
      // loads and stores
      ////////////////////
      OP_LOAD: begin
        hit             = 1'b1;
        lsu.req         = 1'b1;
        oper.regfile_we = 1'b1;
        oper.op_b_sel   = OP_B_IMM; // rs1 + I imm
        lsu.sign_ext    = ~(sub[2] & ~sub[1]); // unsigned only for lbu/lhu
        case (sub[1:0])
          2'b00:   lsu.data_type = DT_BYTE;
          2'b01:   lsu.data_type = DT_HALF;
          default: lsu.data_type = DT_WORD;
        endcase
        if (sub[2:1] == 2'b11 || sub == 3'b011) // lwu, ld and beyond
          illegal = 1'b1;
      end

      OP_STORE: begin
        hit     = 1'b1;
        lsu.req = 1'b1;
        lsu.we  = 1'b1;
        if (!sub[2]) begin
          oper.op_b_sel  = OP_B_IMM;
          oper.imm_b_sel = IMMB_S;
        end else begin
          // no third read port for a register offset
          lsu.req = 1'b0;
          lsu.we  = 1'b0;
          illegal = 1'b1;
        end
        case (instr_i[FLD_FUNCT3_LO+1:FLD_FUNCT3_LO])
          2'b00: lsu.data_type = DT_BYTE;
          2'b01: lsu.data_type = DT_HALF;
          2'b10: lsu.data_type = DT_WORD;
          default: begin
            lsu.req = 1'b0;
            lsu.we  = 1'b0;
            illegal = 1'b1;
          end
        endcase
      end

      ////////////////////
      // system and csr
      ////////////////////
      OP_SYSTEM: begin
        hit = 1'b1;
        if (sub != 3'b111) begin
          illegal = 1'b1;
        end else if (!instr_i[BIT_CSRIMM] && csrfn == 2'b00) begin
          case (sysfn) // plain system events
            SYS_ECALL:  sys.ecall     = 1'b1;
            SYS_EBREAK: sys.ebreak    = 1'b1;
            SYS_MRET:   sys.mret      = 1'b1;
            SYS_WFI:    sys.wfi_flush = 1'b1;
            default:    illegal       = 1'b1;
          endcase
          if (alt) illegal = 1'b1;
        end else begin
          sys.csr_access  = 1'b1;
          oper.regfile_we = 1'b1; // old csr value to rd
          oper.op_b_sel   = OP_B_IMM;
          oper.imm_a_sel  = IMMA_Z;
          if (instr_i[BIT_CSRIMM]) begin
            oper.op_a_sel = OP_A_IMM; // zimm from rs1 field
          end else if (alt) begin
            illegal = 1'b1;
          end
          case (csrfn)
            2'b01:   sys.csr_op = CSR_OP_WRITE;
            2'b10:   sys.csr_op = CSR_OP_SET;
            2'b11:   sys.csr_op = CSR_OP_CLEAR;
            default: csr_illegal = 1'b1;
          endcase
          sys.csr_status = ~csr_illegal & (sysfn == CSR_MSTATUS);
          illegal        = illegal | csr_illegal;
        end
      end

      default: ; // exec_decoder classes
    endcase
  end

  assign mem_hit_o     = hit;
  assign mem_illegal_o = illegal;
  assign oper_o        = oper;
  assign lsu_o         = lsu;
  assign sys_o         = sys;

  // controller takes at most one trap or flush per instruction
  always_comb begin
    a_sys_event_onehot: assert ($onehot0({sys.ecall, sys.ebreak, sys.mret, sys.wfi_flush}))
      else $error("multiple system events for instr %h", instr_i);
  end

endmodule

// ==== source/decode_merge.sv ====
`timescale 1ns/1ps

module decode_merge import decode_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       illegal_c_i,   // compressed expansion failed
  input  logic       deassert_we_i, // stall kill
  input  logic       exec_hit_i,
  input  logic       exec_illegal_i,
  input  oper_sel_t  exec_oper_i,
  input  mdj_ctrl_t  mdj_i,
  input  logic       mem_hit_i,
  input  logic       mem_illegal_i,
  input  oper_sel_t  mem_oper_i,
  input  lsu_ctrl_t  lsu_i,
  input  sys_ctrl_t  sys_i,
  output ctrl_word_t ctrl_o
);

  ctrl_word_t ctrl_d;
  ctrl_word_t ctrl_q;

  always_comb begin
    ctrl_d.oper = exec_hit_i ? exec_oper_i : mem_oper_i; // owner's operands
    ctrl_d.mdj  = mdj_i;
    ctrl_d.lsu  = lsu_i;
    ctrl_d.sys  = sys_i;

    ctrl_d.illegal = illegal_c_i
                   | ~(exec_hit_i | mem_hit_i)      // unknown class
                   | (exec_hit_i & exec_illegal_i)
                   | (mem_hit_i & mem_illegal_i);

    // no mul/div unit in the build
    if (!RV32M_EN) begin
      ctrl_d.mdj.mult_en = 1'b0;
      ctrl_d.mdj.div_en  = 1'b0;
    end

    // stalled item leaves no side effects
    if (deassert_we_i) begin
      ctrl_d.oper.regfile_we = 1'b0;
      ctrl_d.mdj.mult_en     = 1'b0;
      ctrl_d.mdj.div_en      = 1'b0;
      ctrl_d.lsu.req         = 1'b0;
      ctrl_d.mdj.jump        = 1'b0;
      ctrl_d.mdj.branch      = 1'b0;
      ctrl_d.sys.csr_op      = CSR_OP_NONE;
    end
  end

  // single output register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_d;
    end
  end

  assign ctrl_o = ctrl_q;

  // decoders own disjoint classes
  a_one_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(exec_hit_i && mem_hit_i));

  // kill seen one cycle later on the registered word
  a_kill_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    deassert_we_i |=> !(ctrl_o.oper.regfile_we || ctrl_o.mdj.mult_en ||
                        ctrl_o.mdj.div_en || ctrl_o.lsu.req ||
                        ctrl_o.mdj.jump || ctrl_o.mdj.branch) &&
                      (ctrl_o.sys.csr_op == CSR_OP_NONE));

endmodule

// ==== source/decode_top.sv ====
`timescale 1ns/1ps

module decode_top import decode_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [INSTR_W-1:0] instr_i,
  input  logic               illegal_c_i,
  input  logic               deassert_we_i,
  input  logic               branch_phase_i,
  input  logic               jump_phase_i,
  output ctrl_word_t         ctrl_o
);

  logic      exec_hit;
  logic      exec_illegal;
  oper_sel_t exec_oper;
  mdj_ctrl_t mdj;

  logic      mem_hit;
  logic      mem_illegal;
  oper_sel_t mem_oper;
  lsu_ctrl_t lsu;
  sys_ctrl_t sys;

  ////////////////////
  // parallel decoders
  ////////////////////

  exec_decoder u_exec_decoder (
    .instr_i        (instr_i),
    .branch_phase_i (branch_phase_i),
    .jump_phase_i   (jump_phase_i),
    .exec_hit_o     (exec_hit),
    .exec_illegal_o (exec_illegal),
    .oper_o         (exec_oper),
    .mdj_o          (mdj)
  );

  mem_sys_decoder u_mem_sys_decoder (
    .instr_i       (instr_i),
    .mem_hit_o     (mem_hit),
    .mem_illegal_o (mem_illegal),
    .oper_o        (mem_oper),
    .lsu_o         (lsu),
    .sys_o         (sys)
  );

  // combine and register
  decode_merge u_decode_merge (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .illegal_c_i    (illegal_c_i),
    .deassert_we_i  (deassert_we_i),
    .exec_hit_i     (exec_hit),
    .exec_illegal_i (exec_illegal),
    .exec_oper_i    (exec_oper),
    .mdj_i          (mdj),
    .mem_hit_i      (mem_hit),
    .mem_illegal_i  (mem_illegal),
    .mem_oper_i     (mem_oper),
    .lsu_i          (lsu),
    .sys_i          (sys),
    .ctrl_o         (ctrl_o)
  );

endmodule

// ==== verification/tb_decode_vectors.svh ====
`ifndef TB_DECODE_VECTORS_SVH
`define TB_DECODE_VECTORS_SVH

// each row holds instruction, side {illegal_c, deassert_we, branch_phase, jump_phase}
// and expected word
task automatic load_rows();
  ctrl_word_t e;

  ////////////////////
  // alu forms
  ////////////////////
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_REGB, IMMB_I, 1'b1);
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b000, 1'b0), 4'b0000, e);
  e = oper_word(ALU_SUB, OP_A_REGA, OP_B_REGB, IMMB_I, 1'b1);
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b000, 1'b1), 4'b0000, e);
  e = oper_word(ALU_SLTU, OP_A_REGA, OP_B_REGB, IMMB_I, 1'b1);
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b011, 1'b0), 4'b0000, e);
  e = oper_word(ALU_SRA, OP_A_REGA, OP_B_REGB, IMMB_I, 1'b1);
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b101, 1'b1), 4'b0000, e);
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_REGB, IMMB_I, 1'b1);
  e.illegal = 1'b1; // sll has no alt form
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b001, 1'b1), 4'b0000, e);
  e = oper_word(ALU_SLL, OP_A_REGA, OP_B_IMM, IMMB_I, 1'b1);
  add_row(encode_instr(OP_ALU_REG, OPCODE_SHIFT, 3'b001, 1'b0), 4'b0000, e);
  e = oper_word(ALU_SRA, OP_A_REGA, OP_B_IMM, IMMB_I, 1'b1);
  add_row(encode_instr(OP_ALU_REG, OPCODE_SHIFT, 3'b101, 1'b1), 4'b0000, e);
  e = oper_word(ALU_AND, OP_A_REGA, OP_B_IMM, IMMB_I, 1'b1);
  add_row(encode_instr(OP_ALU_IMM, 3'b111, 3'b000, 1'b0), 4'b0000, e); // andi
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_IMM, IMMB_I, 1'b1);
  e.illegal = 1'b1;
  add_row(encode_instr(OP_ALU_IMM, 3'b100, 3'b000, 1'b1), 4'b0000, e);

  // rv32m
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_REGB, IMMB_I, 1'b1);
  e.mdj = '{1'b1, 1'b0, MD_OP_MULL, 2'b00, 1'b0, 1'b0, 1'b0};
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b000, 1'b0) | MEXT_BIT, 4'b0000, e);
  e.mdj = '{1'b1, 1'b0, MD_OP_MULH, 2'b01, 1'b0, 1'b0, 1'b0}; // mulhsu
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b010, 1'b0) | MEXT_BIT, 4'b0000, e);
  e.mdj = '{1'b0, 1'b1, MD_OP_DIV, 2'b11, 1'b0, 1'b0, 1'b0};
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b100, 1'b0) | MEXT_BIT, 4'b0000, e);
  e.mdj = '{1'b0, 1'b1, MD_OP_REM, 2'b00, 1'b0, 1'b0, 1'b0}; // remu
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b111, 1'b0) | MEXT_BIT, 4'b0000, e);

  ////////////////////
  // loads and stores
  ////////////////////
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_IMM, IMMB_I, 1'b1);
  e.lsu = '{1'b1, 1'b0, DT_BYTE, 1'b1, 2'b00};
  add_row(encode_instr(OP_LOAD, 3'b000, 3'b000, 1'b0), 4'b0000, e);
  e.lsu = '{1'b1, 1'b0, DT_HALF, 1'b0, 2'b00}; // lhu
  add_row(encode_instr(OP_LOAD, 3'b101, 3'b000, 1'b0), 4'b0000, e);
  e.lsu = '{1'b1, 1'b0, DT_WORD, 1'b1, 2'b00};
  add_row(encode_instr(OP_LOAD, 3'b010, 3'b000, 1'b0), 4'b0000, e);
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_IMM, IMMB_S, 1'b0);
  e.lsu = '{1'b1, 1'b1, DT_WORD, 1'b0, 2'b00};
  add_row(encode_instr(OP_STORE, 3'b000, 3'b010, 1'b0), 4'b0000, e);
  e = '0;
  e.lsu.data_type = DT_BYTE; // register offset store
  e.illegal       = 1'b1;
  add_row(encode_instr(OP_STORE, 3'b100, 3'b000, 1'b0), 4'b0000, e);

  ////////////////////
  // branch, jump, upper imm
  ////////////////////
  e = oper_word(ALU_EQ, OP_A_REGA, OP_B_REGB, IMMB_I, 1'b0);
  e.mdj.branch = 1'b1;
  add_row(encode_instr(OP_BRANCH, 3'b000, 3'b000, 1'b0), 4'b0010, e);
  e.oper.alu_op = ALU_GEU;
  add_row(encode_instr(OP_BRANCH, 3'b101, 3'b000, 1'b0), 4'b0010, e);
  e = oper_word(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_SB, 1'b0);
  e.mdj.branch = 1'b1; // target phase
  add_row(encode_instr(OP_BRANCH, 3'b000, 3'b000, 1'b0), 4'b0000, e);
  e = oper_word(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_PCINCR, 1'b1);
  e.mdj.jump          = 1'b1;
  e.mdj.regfile_we_ra = 1'b1;
  add_row(encode_instr(OP_U_IMM, OPCODE_JAL, 3'b000, 1'b1), 4'b0000, e);
  e.oper.regfile_we = 1'b0; // jal link without rd write
  add_row(encode_instr(OP_U_IMM, OPCODE_JAL, 3'b000, 1'b0), 4'b0000, e);
  e = oper_word(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_UJ, 1'b0);
  e.mdj.jump = 1'b1;
  add_row(encode_instr(OP_U_IMM, OPCODE_JAL, 3'b000, 1'b1), 4'b0001, e);
  e = oper_word(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_PCINCR, 1'b0);
  e.mdj.jump = 1'b1; // jalr link without rd write
  add_row(encode_instr(OP_BRANCH, OPCODE_JALR, 3'b000, 1'b0), 4'b0000, e);
  e.oper.regfile_we = 1'b1; // jalr link with rd write
  add_row(encode_instr(OP_BRANCH, OPCODE_JALR, 3'b000, 1'b1), 4'b0000, e);
  e = oper_word(ALU_ADD, OP_A_IMM, OP_B_IMM, IMMB_U, 1'b1);
  add_row(encode_instr(OP_U_IMM, OPCODE_LUI, 3'b000, 1'b0), 4'b0000, e);

  ////////////////////
  // system and csr
  ////////////////////
  e = '0;
  e.sys.ecall = 1'b1;
  add_row(encode_sys(SYS_ECALL, 2'b00, 1'b0), 4'b0000, e);
  e = '0;
  e.sys.ebreak = 1'b1;
  add_row(encode_sys(SYS_EBREAK, 2'b00, 1'b0), 4'b0000, e);
  e = '0;
  e.sys.mret = 1'b1;
  add_row(encode_sys(SYS_MRET, 2'b00, 1'b0), 4'b0000, e);
  e = '0;
  e.sys.wfi_flush = 1'b1;
  add_row(encode_sys(SYS_WFI, 2'b00, 1'b0), 4'b0000, e);
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_IMM, IMMB_I, 1'b1);
  e.oper.imm_a_sel = IMMA_Z;
  e.sys = '{1'b1, CSR_OP_SET, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0}; // csrrs mstatus
  add_row(encode_sys(CSR_MSTATUS, 2'b10, 1'b0), 4'b0000, e);
  e = '0;
  e.illegal = 1'b1; // system sub opcode must be 7
  add_row(encode_instr(OP_SYSTEM, 3'b000, 3'b000, 1'b0), 4'b0000, e);

  // stall kill repeats
  e = '0;
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b000, 1'b0), 4'b0100, e);
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b000, 1'b0) | MEXT_BIT, 4'b0100, e);
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_IMM, IMMB_S, 1'b0);
  e.lsu = '{1'b0, 1'b1, DT_WORD, 1'b0, 2'b00}; // we is not killed
  add_row(encode_instr(OP_STORE, 3'b000, 3'b010, 1'b0), 4'b0100, e);
  e = oper_word(ALU_EQ, OP_A_REGA, OP_B_REGB, IMMB_I, 1'b0);
  add_row(encode_instr(OP_BRANCH, 3'b000, 3'b000, 1'b0), 4'b0110, e);
  e = oper_word(ALU_ADD, OP_A_CURRPC, OP_B_IMM, IMMB_PCINCR, 1'b0);
  e.mdj.regfile_we_ra = 1'b1;
  add_row(encode_instr(OP_U_IMM, OPCODE_JAL, 3'b000, 1'b1), 4'b0100, e);
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_IMM, IMMB_I, 1'b0);
  e.oper.imm_a_sel = IMMA_Z;
  e.sys = '{1'b1, CSR_OP_NONE, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
  add_row(encode_sys(CSR_MSTATUS, 2'b10, 1'b0), 4'b0100, e);

  // compressed decode failure and unknown class
  e = oper_word(ALU_ADD, OP_A_REGA, OP_B_REGB, IMMB_I, 1'b1);
  e.illegal = 1'b1;
  add_row(encode_instr(OP_ALU_REG, OPCODE_ALU, 3'b000, 1'b0), 4'b1000, e);
  e = '0;
  e.sys.ecall = 1'b1;
  e.illegal   = 1'b1;
  add_row(encode_sys(SYS_ECALL, 2'b00, 1'b0), 4'b1000, e);
  e = '0;
  e.illegal = 1'b1;
  add_row(encode_instr(5'h1f, 3'b000, 3'b000, 1'b0), 4'b0000, e);
endtask

`endif

// ==== verification/tb_decode_top.sv ====
`timescale 1ns/1ps

module tb_decode_top import decode_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 10;
  localparam logic [INSTR_W-1:0] MEXT_BIT = 32'h1 << BIT_MEXT; // rv32m select

  logic               clk;
  logic               rst_n;
  logic [INSTR_W-1:0] instr;
  logic               illegal_c;
  logic               deassert_we;
  logic               branch_phase;
  logic               jump_phase;
  ctrl_word_t         ctrl;

  // stimulus table
  logic [INSTR_W-1:0] row_instr[$];
  logic [3:0]         row_side[$]; // {illegal_c, deassert_we, branch_phase, jump_phase}
  ctrl_word_t         row_exp[$];
  int                 n_rows;
  bit                 rows_loaded;

  int oper_errs;
  int mdj_errs;
  int lsu_errs;
  int sys_errs;
  int ill_errs;

  decode_top u_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .instr_i        (instr),
    .illegal_c_i    (illegal_c),
    .deassert_we_i  (deassert_we),
    .branch_phase_i (branch_phase),
    .jump_phase_i   (jump_phase),
    .ctrl_o         (ctrl)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // row builders
  ////////////////////

  function automatic logic [INSTR_W-1:0] encode_instr(input logic [4:0] cls,
                                                      input logic [2:0] sub,
                                                      input logic [2:0] f3,
                                                      input logic       alt);
    logic [INSTR_W-1:0] w;
    w = '0;
    w[FLD_CLASS_HI:FLD_CLASS_LO]   = cls;
    w[FLD_SUB_HI:FLD_SUB_LO]       = sub;
    w[FLD_FUNCT3_HI:FLD_FUNCT3_LO] = f3;
    w[BIT_ALT]                     = alt;
    return w;
  endfunction

  // system group always uses sub opcode 7
  function automatic logic [INSTR_W-1:0] encode_sys(input logic [11:0] fn,
                                                    input logic [1:0]  csrfn,
                                                    input logic        csrimm);
    logic [INSTR_W-1:0] w;
    w = encode_instr(OP_SYSTEM, 3'b111, 3'b000, 1'b0);
    w[FLD_SYSFN_HI:FLD_SYSFN_LO] = fn;
    w[FLD_CSRFN_HI:FLD_CSRFN_LO] = csrfn;
    w[BIT_CSRIMM]                = csrimm;
    return w;
  endfunction

  // expected word with only operand controls set
  function automatic ctrl_word_t oper_word(input alu_op_e    op,
                                           input op_a_sel_e  a_sel,
                                           input op_b_sel_e  b_sel,
                                           input imm_b_sel_e imm_b,
                                           input logic       we);
    ctrl_word_t w;
    w = '0;
    w.oper.alu_op     = op;
    w.oper.op_a_sel   = a_sel;
    w.oper.op_b_sel   = b_sel;
    w.oper.imm_b_sel  = imm_b;
    w.oper.regfile_we = we;
    return w;
  endfunction

  function automatic void add_row(input logic [INSTR_W-1:0] instr_w,
                                  input logic [3:0]         side,
                                  input ctrl_word_t         expected);
    row_instr.push_back(instr_w);
    row_side.push_back(side);
    row_exp.push_back(expected);
  endfunction

  `include "tb_decode_vectors.svh"

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_oper(input string where, input oper_sel_t got, input oper_sel_t expected);
    if (got !== expected) begin
      oper_errs++;
      $display("mismatch %s ctrl_o.oper got %h exp %h", where, got, expected);
    end
  endtask

  task automatic check_mdj(input string where, input mdj_ctrl_t got, input mdj_ctrl_t expected);
    if (got !== expected) begin
      mdj_errs++;
      $display("mismatch %s ctrl_o.mdj got %h exp %h", where, got, expected);
    end
  endtask

  task automatic check_lsu(input string where, input lsu_ctrl_t got, input lsu_ctrl_t expected);
    if (got !== expected) begin
      lsu_errs++;
      $display("mismatch %s ctrl_o.lsu got %h exp %h", where, got, expected);
    end
  endtask

  task automatic check_sys(input string where, input sys_ctrl_t got, input sys_ctrl_t expected);
    if (got !== expected) begin
      sys_errs++;
      $display("mismatch %s ctrl_o.sys got %h exp %h", where, got, expected);
    end
  endtask

  task automatic check_illegal(input string where, input logic got, input logic expected);
    if (got !== expected) begin
      ill_errs++;
      $display("mismatch %s ctrl_o.illegal got %h exp %h", where, got, expected);
    end
  endtask

  task automatic check_word(input string where, input ctrl_word_t got, input ctrl_word_t expected);
    check_oper(where, got.oper, expected.oper);
    check_mdj(where, got.mdj, expected.mdj);
    check_lsu(where, got.lsu, expected.lsu);
    check_sys(where, got.sys, expected.sys);
    check_illegal(where, got.illegal, expected.illegal);
  endtask

  task automatic apply_row(input int i);
    instr = row_instr[i];
    {illegal_c, deassert_we, branch_phase, jump_phase} = row_side[i];
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : stimulus
    int total;
    clk          = 1'b0;
    rst_n        = 1'b0;
    instr        = '0;
    illegal_c    = 1'b0;
    deassert_we  = 1'b0;
    branch_phase = 1'b0;
    jump_phase   = 1'b0;
    load_rows();
    n_rows      = row_exp.size();
    rows_loaded = 1'b1;

    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_word("reset", ctrl, '0); // no rising edge since release yet

    // drive on falling edge and sample on the next one
    for (int i = 0; i < n_rows; i++) begin
      apply_row(i);
      @(negedge clk);
      check_word($sformatf("row %0d", i), ctrl, row_exp[i]);
    end

    total = oper_errs + mdj_errs + lsu_errs + sys_errs + ill_errs;
    $display("errors oper %0d mdj %0d lsu %0d sys %0d illegal %0d over %0d rows",
             oper_errs, mdj_errs, lsu_errs, sys_errs, ill_errs, n_rows);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // reset plus one cycle per row plus margin
  initial begin : watchdog
    wait (rows_loaded);
    #((n_rows + 20) * CLK_PERIOD);
    $display("timeout: table walk did not finish within %0d cycles", n_rows + 20);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+verification
source/decode_pkg.sv
source/exec_decoder.sv
source/mem_sys_decoder.sv
source/decode_merge.sv
source/decode_top.sv
verification/tb_decode_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log &&
  verilator --binary --timing --assert -f list.f --top-module tb_decode_top -o sim_decode &&
  ./obj_dir/sim_decode | tee sim.log ||
  { echo "build or simulation error"; exit 1; }

grep -qx "PASS: all tests" sim.log &&
  echo "decode testbench passed" ||
  { echo "decode testbench failed"; exit 1; }
